// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire isa_pkg::word_t a,
	input wire isa_pkg::word_t b,
	input wire ctrl_pkg::alu_op_t op,
	input wire ctrl_pkg::branch_t branch_type,
	output isa_pkg::word_t result,
	output logic bcond
);

	always_comb begin
		case (op)
			ctrl_pkg::ALU_ADD: begin
				result = a + b;
			end
			ctrl_pkg::ALU_SUB: begin
				result = a - b;
			end
			ctrl_pkg::ALU_AND: begin
				result = a & b;
			end
			ctrl_pkg::ALU_OR: begin
				result = a | b;
			end
			ctrl_pkg::ALU_NOT: begin
				result = ~a;
			end
			ctrl_pkg::ALU_TCP: begin
				result = ~a + isa_pkg::word_t'(1);
			end
			ctrl_pkg::ALU_SHL: begin
				result = {a[14:0], 1'b0};
			end
			// arithmetic shift, sign bit is kept
			ctrl_pkg::ALU_SHR: begin
				result = {a[15], a[15:1]};
			end
			ctrl_pkg::ALU_PASS_B: begin
				result = b;
			end
			ctrl_pkg::ALU_OR_LOW: begin
				result = a | {8'h00, b[7:0]};
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// GZ and LZ only look at a, read as signed
	always_comb begin
		case (branch_type)
			ctrl_pkg::NE: begin
				bcond = (a != b);
			end
			ctrl_pkg::EQ: begin
				bcond = (a == b);
			end
			ctrl_pkg::GZ: begin
				bcond = !a[15] && (a != '0);
			end
			default: begin
				bcond = a[15];
			end
		endcase
	end

endmodule

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input wire clk,
	input wire reset_n,
	input wire isa_pkg::opcode_t opcode,
	input wire isa_pkg::funct_t funct,
	input wire bcond,
	output logic pc_write,
	output logic pc_write_cond,
	output logic pc_src,
	output logic pc_from_reg,
	output logic i_or_d,
	output logic ir_write,
	output logic mem_read,
	output logic mem_write,
	output logic mem_to_reg,
	output logic reg_write,
	output ctrl_pkg::wr_dst_t wr_dst,
	output ctrl_pkg::src_a_t src_a,
	output ctrl_pkg::src_b_t src_b,
	output ctrl_pkg::alu_op_t alu_op,
	output ctrl_pkg::branch_t branch_type,
	output logic wwd,
	output logic new_inst,
	output logic halt
);

	ctrl_pkg::ctrl_state_t state;
	ctrl_pkg::ctrl_state_t state_next;
	ctrl_pkg::alu_op_t exec_op;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ctrl_pkg::IF;
		end else begin
			state <= state_next;
		end
	end

	// alu function used in EX
	always_comb begin
		case (opcode)
			isa_pkg::ORI: exec_op = ctrl_pkg::ALU_OR_LOW;
			isa_pkg::LHI: exec_op = ctrl_pkg::ALU_PASS_B;
			isa_pkg::RTYPE: begin
				case (funct)
					isa_pkg::SUB: exec_op = ctrl_pkg::ALU_SUB;
					isa_pkg::AND: exec_op = ctrl_pkg::ALU_AND;
					isa_pkg::ORR: exec_op = ctrl_pkg::ALU_OR;
					isa_pkg::NOT: exec_op = ctrl_pkg::ALU_NOT;
					isa_pkg::TCP: exec_op = ctrl_pkg::ALU_TCP;
					isa_pkg::SHL: exec_op = ctrl_pkg::ALU_SHL;
					isa_pkg::SHR: exec_op = ctrl_pkg::ALU_SHR;
					default: exec_op = ctrl_pkg::ALU_ADD;
				endcase
			end
			// ADI and the load/store address add
			default: exec_op = ctrl_pkg::ALU_ADD;
		endcase
	end

	always_comb begin
		case (opcode)
			isa_pkg::BEQ: branch_type = ctrl_pkg::EQ;
			isa_pkg::BGZ: branch_type = ctrl_pkg::GZ;
			isa_pkg::BLZ: branch_type = ctrl_pkg::LZ;
			default: branch_type = ctrl_pkg::NE;
		endcase
	end

	always_comb begin
		state_next = state;
		pc_write = 1'b0;
		pc_write_cond = 1'b0;
		pc_src = 1'b0;
		pc_from_reg = 1'b0;
		i_or_d = 1'b0;
		ir_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_to_reg = 1'b0;
		reg_write = 1'b0;
		wr_dst = ctrl_pkg::DST_RD;
		src_a = ctrl_pkg::SRC_A_PC;
		src_b = ctrl_pkg::SRC_B_ONE;
		alu_op = ctrl_pkg::ALU_ADD;
		wwd = 1'b0;
		new_inst = 1'b0;
		halt = 1'b0;
		case (state)
			// fetch and pc <= pc + 1 through the alu
			ctrl_pkg::IF: begin
				mem_read = 1'b1;
				ir_write = 1'b1;
				pc_write = 1'b1;
				state_next = ctrl_pkg::ID;
			end
			// jumps, WWD and HLT finish here
			ctrl_pkg::ID: begin
				case (opcode)
					isa_pkg::JMP, isa_pkg::JAL: begin
						pc_write = 1'b1;
						pc_src = 1'b1;
						// link value is the pc + 1 latched at the end of IF
						reg_write = (opcode == isa_pkg::JAL);
						wr_dst = ctrl_pkg::DST_LINK;
						new_inst = 1'b1;
						state_next = ctrl_pkg::IF;
					end
					isa_pkg::RTYPE: begin
						case (funct)
							isa_pkg::JPR, isa_pkg::JRL: begin
								pc_write = 1'b1;
								pc_from_reg = 1'b1;
								reg_write = (funct == isa_pkg::JRL);
								wr_dst = ctrl_pkg::DST_LINK;
								new_inst = 1'b1;
								state_next = ctrl_pkg::IF;
							end
							isa_pkg::WWD: begin
								wwd = 1'b1;
								new_inst = 1'b1;
								state_next = ctrl_pkg::IF;
							end
							isa_pkg::HLT: begin
								new_inst = 1'b1;
								state_next = ctrl_pkg::HALT;
							end
							default: begin
								state_next = ctrl_pkg::EX;
							end
						endcase
					end
					isa_pkg::BNE, isa_pkg::BEQ, isa_pkg::BGZ, isa_pkg::BLZ,
					isa_pkg::ADI, isa_pkg::ORI, isa_pkg::LHI,
					isa_pkg::LWD, isa_pkg::SWD: begin
						state_next = ctrl_pkg::EX;
					end
					// unknown opcode retires as a no-op
					default: begin
						new_inst = 1'b1;
						state_next = ctrl_pkg::IF;
					end
				endcase
			end
			ctrl_pkg::EX: begin
				src_a = ctrl_pkg::SRC_A_REG;
				src_b = ctrl_pkg::SRC_B_IMM;
				alu_op = exec_op;
				case (opcode)
					isa_pkg::BNE, isa_pkg::BEQ, isa_pkg::BGZ, isa_pkg::BLZ: begin
						// compare here, the target comes from the adder in cpu
						src_b = ctrl_pkg::SRC_B_REG;
						// pc only moves on a taken branch
						pc_write_cond = bcond;
						pc_src = 1'b1;
						new_inst = 1'b1;
						state_next = ctrl_pkg::IF;
					end
					isa_pkg::LWD, isa_pkg::SWD: begin
						state_next = ctrl_pkg::MEM;
					end
					isa_pkg::RTYPE: begin
						src_b = ctrl_pkg::SRC_B_REG;
						state_next = ctrl_pkg::WB;
					end
					default: begin
						state_next = ctrl_pkg::WB;
					end
				endcase
			end
			// address comes from the alu output register
			ctrl_pkg::MEM: begin
				i_or_d = 1'b1;
				if (opcode == isa_pkg::LWD) begin
					mem_read = 1'b1;
					state_next = ctrl_pkg::WB;
				end else begin
					mem_write = 1'b1;
					new_inst = 1'b1;
					state_next = ctrl_pkg::IF;
				end
			end
			ctrl_pkg::WB: begin
				reg_write = 1'b1;
				mem_to_reg = (opcode == isa_pkg::LWD);
				if (opcode != isa_pkg::RTYPE) begin
					wr_dst = ctrl_pkg::DST_RT;
				end
				new_inst = 1'b1;
				state_next = ctrl_pkg::IF;
			end
			default: begin
				halt = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input wire clk,
	input wire reset_n,
	output logic read_m,
	output logic write_m,
	output isa_pkg::word_t address,
	inout wire isa_pkg::word_t data,
	output isa_pkg::word_t num_inst,
	output isa_pkg::word_t output_port,
	output logic is_halted
);

	isa_pkg::word_t pc;
	isa_pkg::word_t ir;
	isa_pkg::word_t mdr;
	isa_pkg::word_t alu_out_reg;
	isa_pkg::word_t branch_target;
	isa_pkg::word_t pc_next;
	isa_pkg::word_t jump_target;
	isa_pkg::word_t immediate;

	isa_pkg::opcode_t opcode;
	isa_pkg::funct_t funct;
	isa_pkg::imm_t imm_field;
	isa_pkg::target_t target_field;

	logic pc_write, pc_write_cond, pc_src, pc_from_reg;
	logic i_or_d, ir_write, mem_read, mem_write, mem_to_reg, reg_write;
	logic wwd, new_inst, halt, bcond;
	ctrl_pkg::wr_dst_t wr_dst;
	ctrl_pkg::src_a_t src_a;
	ctrl_pkg::src_b_t src_b;
	ctrl_pkg::alu_op_t alu_op;
	ctrl_pkg::branch_t branch_type;

	isa_pkg::reg_addr_t write_reg;
	isa_pkg::word_t write_data, read_out1, read_out2;
	isa_pkg::word_t alu_a, alu_b, alu_result;

	// instruction fields
	assign opcode = isa_pkg::opcode_t'(ir[15:12]);
	assign funct = isa_pkg::funct_t'(ir[5:0]);
	assign imm_field = ir[7:0];
	assign target_field = ir[11:0];

	always_comb begin
		case (opcode)
			isa_pkg::ORI: immediate = {8'h00, imm_field};
			isa_pkg::LHI: immediate = {imm_field, 8'h00};
			default: immediate = {{8{imm_field[7]}}, imm_field};
		endcase
	end

	// memory bus, driven only during a store
	assign read_m = mem_read;
	assign write_m = mem_write;
	assign address = i_or_d ? alu_out_reg : pc;
	assign data = write_m ? read_out2 : 'z;

	assign is_halted = halt;

	assign alu_a = (src_a == ctrl_pkg::SRC_A_REG) ? read_out1 : pc;

	always_comb begin
		case (src_b)
			ctrl_pkg::SRC_B_REG: alu_b = read_out2;
			ctrl_pkg::SRC_B_ONE: alu_b = isa_pkg::word_t'(1);
			ctrl_pkg::SRC_B_IMM: alu_b = immediate;
			default: alu_b = '0;
		endcase
	end

	always_comb begin
		case (wr_dst)
			ctrl_pkg::DST_RT: write_reg = ir[9:8];
			ctrl_pkg::DST_LINK: write_reg = isa_pkg::link_reg;
			default: write_reg = ir[7:6];
		endcase
	end

	assign write_data = mem_to_reg ? mdr : alu_out_reg;

	// pc is already pc + 1 once IF is over
	assign jump_target = pc_write_cond ? branch_target : {pc[15:12], target_field};

	always_comb begin
		if (pc_from_reg) begin
			pc_next = read_out1;
		end else if (pc_src) begin
			pc_next = jump_target;
		end else begin
			pc_next = alu_result;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			num_inst <= '0;
			output_port <= '0;
		end else begin
			if (pc_write || pc_write_cond) begin
				pc <= pc_next;
			end
			if (new_inst) begin
				num_inst <= num_inst + isa_pkg::word_t'(1);
			end
			if (wwd) begin
				output_port <= read_out1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ir_write) begin
			ir <= data;
		end
		// ID onward, so pc + 1 plus the offset
		if (!ir_write) begin
			branch_target <= pc + immediate;
		end
		if (mem_read && i_or_d) begin
			mdr <= data;
		end
		alu_out_reg <= alu_result;
	end

	control_unit u_control_unit (
		.clk(clk),
		.reset_n(reset_n),
		.opcode(opcode),
		.funct(funct),
		.bcond(bcond),
		.pc_write(pc_write),
		.pc_write_cond(pc_write_cond),
		.pc_src(pc_src),
		.pc_from_reg(pc_from_reg),
		.i_or_d(i_or_d),
		.ir_write(ir_write),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_to_reg(mem_to_reg),
		.reg_write(reg_write),
		.wr_dst(wr_dst),
		.src_a(src_a),
		.src_b(src_b),
		.alu_op(alu_op),
		.branch_type(branch_type),
		.wwd(wwd),
		.new_inst(new_inst),
		.halt(halt)
	);

	register_file u_register_file (
		.clk(clk),
		.reset_n(reset_n),
		.read1(ir[11:10]),
		.read2(ir[9:8]),
		.write_reg(write_reg),
		.write_data(write_data),
		.reg_write(reg_write),
		.read_out1(read_out1),
		.read_out2(read_out2)
	);

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(alu_op),
		.branch_type(branch_type),
		.result(alu_result),
		.bcond(bcond)
	);

endmodule

`default_nettype wire

// File: ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	typedef enum logic [2:0] {IF, ID, EX, MEM, WB, HALT} ctrl_state_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS_B,
		// or with the low byte of b only, for ORI
		ALU_OR_LOW
	} alu_op_t;

	typedef enum logic [1:0] {NE, EQ, GZ, LZ} branch_t;

	// alu operand selects
	typedef enum logic {SRC_A_PC, SRC_A_REG} src_a_t;
	typedef enum logic [1:0] {SRC_B_REG, SRC_B_ONE, SRC_B_IMM, SRC_B_ZERO} src_b_t;

	// register file destination: rd is bits 7:6, rt is bits 9:8
	typedef enum logic [1:0] {DST_RD, DST_RT, DST_LINK} wr_dst_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

	// field widths of the instruction word
	localparam int WORD_W = 16;
	localparam int OPCODE_W = 4;
	localparam int REG_W = 2;
	localparam int FUNCT_W = 6;
	localparam int IMM_W = 8;
	localparam int TARGET_W = 12;

	// data, address and instruction word
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0] reg_addr_t;
	typedef logic [IMM_W-1:0] imm_t;
	typedef logic [TARGET_W-1:0] target_t;

	typedef enum logic [OPCODE_W-1:0] {
		BNE = 4'd0,
		BEQ = 4'd1,
		BGZ = 4'd2,
		BLZ = 4'd3,
		ADI = 4'd4,
		ORI = 4'd5,
		LHI = 4'd6,
		LWD = 4'd7,
		SWD = 4'd8,
		JMP = 4'd9,
		JAL = 4'd10,
		RTYPE = 4'd15
	} opcode_t;

	// function codes, only meaningful with the RTYPE opcode
	typedef enum logic [FUNCT_W-1:0] {
		ADD = 6'd0,
		SUB = 6'd1,
		AND = 6'd2,
		ORR = 6'd3,
		NOT = 6'd4,
		TCP = 6'd5,
		SHL = 6'd6,
		SHR = 6'd7,
		JPR = 6'd25,
		JRL = 6'd26,
		WWD = 6'd28,
		HLT = 6'd29
	} funct_t;

	// JAL and JRL put the return address here
	localparam reg_addr_t link_reg = 2'd2;

endpackage

`default_nettype wire

// File: multicycle_cpu.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
alu.sv
register_file.sv
control_unit.sv
cpu.sv
tb_cpu.sv

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input wire clk,
	input wire reset_n,
	input wire isa_pkg::reg_addr_t read1,
	input wire isa_pkg::reg_addr_t read2,
	input wire isa_pkg::reg_addr_t write_reg,
	input wire isa_pkg::word_t write_data,
	input wire reg_write,
	output isa_pkg::word_t read_out1,
	output isa_pkg::word_t read_out2
);

	isa_pkg::word_t regs [4];

	// reads see the old value during a write in the same cycle
	assign read_out1 = regs[read1];
	assign read_out2 = regs[read2];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[write_reg] <= write_data;
		end
	end

endmodule

`default_nettype wire

// File: tb_cpu_programs.svh
`ifndef TB_CPU_PROGRAMS_SVH
`define TB_CPU_PROGRAMS_SVH

// programs stored back to back, each one is loaded at address 0
// 0 alu and immediates, 1 load and store, 2 branches, 3 jumps
localparam int num_programs = 4;
localparam int rom_words = 83;
localparam int out_words = 12;

// program 0 gets the low byte of its first four words from the lcg
localparam int lcg_program = 0;
localparam int lcg_patches = 4;

isa_pkg::word_t program_rom [rom_words] = '{
	// r0 = {c0, c1}, r1 = {c2, c3}, every alu op into r2, adi with 0x85 into r3
	16'h6000, 16'h5000, 16'h6100, 16'h5500, 16'hf01c, 16'hf41c,
	16'hf180, 16'hf81c, 16'hf181, 16'hf81c, 16'hf182, 16'hf81c,
	16'hf183, 16'hf81c, 16'hf084, 16'hf81c, 16'hf085, 16'hf81c,
	16'hf086, 16'hf81c, 16'hf087, 16'hf81c, 16'h4785, 16'hfc1c,
	16'hf01d,
	// store r0 at 0x4005, load into r3, then store r3 + 1 at 0x3fff and reload
	16'h6012, 16'h5034, 16'h6140, 16'h8405, 16'h7705, 16'hfc1c,
	16'h4e01, 16'h86ff, 16'h74ff, 16'hf01c, 16'hf01d,
	// r0 = 5, r1 = 0, r2 = -3, r3 counts the markers
	16'h4405, 16'h46fd, 16'h4701, 16'hfc1c, 16'h0101, 16'hf01c,
	16'h1101, 16'h4f01, 16'hfc1c, 16'h1501, 16'hf01c, 16'h0501,
	16'h2001, 16'hf81c, 16'h2402, 16'h4f01, 16'hfc1c, 16'h2801,
	16'h3801, 16'hf01c, 16'h3001, 16'h3401, 16'h4f01, 16'hfc1c,
	// forward to 28, back to 25, then forward to the halt
	16'h0103, 16'h4f01, 16'hfc1c, 16'h1503, 16'h15fc, 16'hf01c,
	16'hf81c, 16'hf01d,
	// jmp over a marker, jal and jrl into the routine at 12
	16'h4407, 16'h9003, 16'hf01c, 16'h4701, 16'hfc1c, 16'ha00c,
	16'hf81c, 16'h440c, 16'hf01a, 16'hf81c, 16'hf01d, 16'hf01c,
	16'h4f01, 16'hfc1c, 16'hf819
};

int prog_start [num_programs] = '{0, 25, 36, 68};
int prog_len [num_programs] = '{25, 11, 32, 15};

// expected output_port values, program 0 is computed from its lcg constants
int out_start [num_programs] = '{0, 0, 2, 7};
int out_len [num_programs] = '{0, 2, 5, 5};
isa_pkg::word_t expected_outputs [out_words] = '{
	16'h1234, 16'h1235,
	16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0005,
	// links from jal at 5 and jrl at 8
	16'h0001, 16'h0002, 16'h0006, 16'h0003, 16'h0009
};

// retired instructions, hlt included
isa_pkg::word_t expected_count [num_programs] = '{16'd25, 16'd11, 16'd26, 16'd16};

isa_pkg::word_t check_addr [num_programs] = '{16'h0006, 16'h3fff, 16'h0000, 16'h0000};
isa_pkg::word_t check_data [num_programs] = '{16'hf180, 16'h1235, 16'h4405, 16'h4407};

`endif

// File: tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	localparam int clk_period = 40;
	localparam int reset_cycles = 3;
	localparam int hold_cycles = 5;
	localparam int mem_words = 65536;

	logic clk;
	logic reset_n;
	logic read_m;
	logic write_m;
	isa_pkg::word_t address;
	wire isa_pkg::word_t data;
	isa_pkg::word_t num_inst;
	isa_pkg::word_t output_port;
	logic is_halted;

	isa_pkg::word_t mem [mem_words];
	isa_pkg::word_t expected_q [$];
	isa_pkg::word_t last_expected;
	logic [31:0] lcg_state;

	`include "tb_cpu_programs.svh"

	logic [7:0] lcg_bytes [lcg_patches];

	cpu uut (
		.clk(clk),
		.reset_n(reset_n),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.data(data),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	// memory answers within the same cycle
	assign data = read_m ? mem[address] : 'z;

	always @(posedge clk) begin
		if (write_m) begin
			mem[address] <= data;
		end
	end

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic fail_run();
		$display("Regression failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input isa_pkg::word_t actual, input isa_pkg::word_t expected,
			input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
			fail_run();
		end
	endtask

	task automatic check_count(input isa_pkg::word_t actual, input isa_pkg::word_t expected,
			input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			fail_run();
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
			fail_run();
		end
	endtask

	// output_port only shows a change, so a repeated value stays invisible
	task automatic expect_output(input isa_pkg::word_t value);
		if (value !== last_expected) begin
			expected_q.push_back(value);
			last_expected = value;
		end
	endtask

	task automatic expect_alu_results(input isa_pkg::word_t a, input isa_pkg::word_t b);
		expect_output(a);
		expect_output(b);
		expect_output(a + b);
		expect_output(a - b);
		expect_output(a & b);
		expect_output(a | b);
		expect_output(~a);
		expect_output(16'd0 - a);
		expect_output(a << 1);
		// shr keeps the sign bit
		expect_output(isa_pkg::word_t'($signed(a) >>> 1));
		// adi at word 22, 0x85 sign extended
		expect_output(b + 16'hff85);
	endtask

	task automatic load_program(input int p);
		isa_pkg::word_t word;
		for (int a = 0; a < mem_words; a++) begin
			mem[a] <= isa_pkg::word_t'(a) ^ 16'h5a5a;
		end
		for (int i = 0; i < prog_len[p]; i++) begin
			word = program_rom[prog_start[p] + i];
			if (p == lcg_program && i < lcg_patches) begin
				word[7:0] = lcg_bytes[i];
			end
			mem[i] <= word;
		end
	endtask

	initial begin : run_programs
		isa_pkg::word_t seen [$];
		isa_pkg::word_t prev_port;
		reset_n = 1'b0;
		lcg_state = 32'd64548;
		for (int p = 0; p < num_programs; p++) begin
			@(posedge clk);
			reset_n <= 1'b0;
			if (p == lcg_program) begin
				for (int i = 0; i < lcg_patches; i++) begin
					lcg_bytes[i] = lcg_byte();
				end
			end
			load_program(p);
			expected_q.delete();
			last_expected = 16'h0000;
			if (p == lcg_program) begin
				expect_alu_results({lcg_bytes[0], lcg_bytes[1]}, {lcg_bytes[2], lcg_bytes[3]});
			end else begin
				for (int i = 0; i < out_len[p]; i++) begin
					expect_output(expected_outputs[out_start[p] + i]);
				end
			end
			repeat (reset_cycles) @(posedge clk);
			reset_n <= 1'b1;
			// the core still holds its reset state here
			@(negedge clk);
			check_word(output_port, 16'h0000, $sformatf("program %0d output_port after reset", p));
			check_count(num_inst, 16'd0, $sformatf("program %0d num_inst after reset", p));
			check_flag(is_halted, 1'b0, $sformatf("program %0d is_halted after reset", p));
			// first fetch from address 0
			check_flag(read_m, 1'b1, $sformatf("program %0d read_m after reset", p));
			check_flag(write_m, 1'b0, $sformatf("program %0d write_m after reset", p));
			check_word(address, 16'h0000, $sformatf("program %0d address after reset", p));
			seen.delete();
			prev_port = output_port;
			while (is_halted !== 1'b1) begin
				@(negedge clk);
				if (output_port !== prev_port) begin
					seen.push_back(output_port);
					prev_port = output_port;
				end
			end
			check_count(num_inst, expected_count[p], $sformatf("program %0d num_inst", p));
			for (int k = 0; k < hold_cycles; k++) begin
				@(negedge clk);
				check_flag(is_halted, 1'b1, $sformatf("program %0d is_halted after hlt", p));
				check_count(num_inst, expected_count[p],
					$sformatf("program %0d num_inst after hlt", p));
				check_word(output_port, last_expected,
					$sformatf("program %0d output_port after hlt", p));
			end
			check_count(isa_pkg::word_t'(seen.size()), isa_pkg::word_t'(expected_q.size()),
				$sformatf("program %0d number of outputs", p));
			for (int i = 0; i < seen.size(); i++) begin
				check_word(seen[i], expected_q[i], $sformatf("program %0d output %0d", p, i));
			end
			check_word(mem[check_addr[p]], check_data[p],
				$sformatf("program %0d memory word at %h", p, check_addr[p]));
			$display("program %0d done after %0d instructions", p, num_inst);
		end
		$display("Regression passed");
		$finish;
	end

	// generous bound from the total program length
	initial begin : watchdog
		int total_words;
		int limit;
		total_words = 0;
		for (int p = 0; p < num_programs; p++) begin
			total_words += prog_len[p];
		end
		limit = total_words * 10 * 20 + num_programs * (reset_cycles + hold_cycles + 4);
		repeat (limit) @(posedge clk);
		$display("error: the processor never halted within %0d cycles", limit);
		fail_run();
	end

endmodule

`default_nettype wire
